/* nes_loader_defs.svh */
// ##############################
// iNES loader constants
// Header layout, memory map, flag bit positions
// ##############################
`ifndef NES_LOADER_DEFS_SVH
`define NES_LOADER_DEFS_SVH

`define INES_HDR_LEN      16
`define INES_MAGIC0       8'h4E      // 'N'
`define INES_MAGIC1       8'h45      // 'E'
`define INES_MAGIC2       8'h53      // 'S'
`define INES_MAGIC3       8'h1A
`define INES_TRAINER_BIT  2          // Byte 6

`define MEM_ADDR_W        22
`define PRG_BASE          22'h000000
`define CHR_BASE          22'h200000
`define PRG_PAGE_SHIFT    14         // 16 KiB pages
`define CHR_PAGE_SHIFT    13         // 8 KiB pages

`define CE_PHASES         4

// Mapper flag word fields
`define FLAG_PRG_LSB      8
`define FLAG_CHR_LSB      11
`define FLAG_MIRROR       14
`define FLAG_CHR_RAM      15
`define FLAG_FOUR_SCREEN  16
`define FLAG_NES2_LSB     17

`endif

/* ines_pkg.sv */
// ##############################
// iNES image types
// Header fields, sizes and memory addresses
// ##############################
`default_nettype none

`include "nes_loader_defs.svh"

package ines_pkg;

	// One byte of the image or of the header
	typedef logic [7:0] byte_t;

	// log2 of the page count, saturating at 7
	typedef logic [2:0] size_code_t;

	// Flag word handed to the console core
	typedef logic [31:0] mapper_flags_t;

	// Cartridge memory space
	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

	// Bytes still to load in the current region
	typedef logic [`MEM_ADDR_W-1:0] byte_count_t;

endpackage

`default_nettype wire

/* loader_pkg.sv */
// ##############################
// Loader control types
// ##############################
`default_nettype none

package loader_pkg;

	typedef enum logic [2:0] {
		st_header,
		st_prg,
		st_chr,
		st_done,
		st_fail
	} loader_state_t;

	typedef enum logic {
		region_prg,
		region_chr
	} region_t;

endpackage

`default_nettype wire

/* ines_header.sv */
// ##############################
// iNES header capture
// Stores the 16 header bytes, checks them and builds the flag word
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "nes_loader_defs.svh"

module ines_header (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    hdr_capture,
	input  wire [3:0]              hdr_index,
	input  ines_pkg::byte_t        byte_data,
	input  wire                    invert_mirroring,
	input  wire                    flags_latch,
	output logic                   hdr_ok,
	output ines_pkg::byte_t        prg_pages,
	output ines_pkg::byte_t        chr_pages,
	output ines_pkg::mapper_flags_t mapper_flags
);

	ines_pkg::byte_t hdr_mem [`INES_HDR_LEN];
	ines_pkg::mapper_flags_t flags_next;
	logic is_nes20;
	logic tail_nonzero;
	logic is_dirty;
	logic [7:0] mapper_num;

	// Smallest k with pages <= 2**k
	function automatic ines_pkg::size_code_t size_code(input ines_pkg::byte_t pages);
		ines_pkg::size_code_t code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if ({1'b0, pages} <= (9'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (hdr_capture)
			hdr_mem[hdr_index] <= byte_data;
	end

	assign prg_pages = hdr_mem[4];
	assign chr_pages = hdr_mem[5];

	// Magic word must match and trainers are not supported
	assign hdr_ok = (hdr_mem[0] == `INES_MAGIC0) && (hdr_mem[1] == `INES_MAGIC1) &&
			(hdr_mem[2] == `INES_MAGIC2) && (hdr_mem[3] == `INES_MAGIC3) &&
			!hdr_mem[6][`INES_TRAINER_BIT];

	assign is_nes20 = (hdr_mem[7][3:2] == 2'b10);

	always_comb begin
		tail_nonzero = 1'b0;
		for (int i = 8; i < `INES_HDR_LEN; i++)
			tail_nonzero = tail_nonzero | (hdr_mem[i] != 8'h00);
	end

	// Old dumps often carry junk in bytes 8..15
	assign is_dirty = !is_nes20 && tail_nonzero;
	assign mapper_num = {is_dirty ? 4'h0 : hdr_mem[7][7:4], hdr_mem[6][7:4]};

	always_comb begin
		flags_next = '0;
		flags_next[7:0] = mapper_num;
		flags_next[`FLAG_PRG_LSB +: 3] = size_code(prg_pages);
		flags_next[`FLAG_CHR_LSB +: 3] = size_code(chr_pages);
		flags_next[`FLAG_MIRROR] = hdr_mem[6][0] ^ invert_mirroring;
		flags_next[`FLAG_CHR_RAM] = (chr_pages == 8'h00);
		flags_next[`FLAG_FOUR_SCREEN] = hdr_mem[6][3];
		flags_next[`FLAG_NES2_LSB +: 8] = is_nes20 ? hdr_mem[8] : 8'h00;   // Extended mapper bits
	end

	always_ff @(posedge clk) begin
		if (reset)
			mapper_flags <= '0;
		else if (flags_latch)
			mapper_flags <= flags_next;
	end

endmodule

`default_nettype wire

/* rom_addr_gen.sv */
// ##############################
// ROM address generator
// Address and remaining-byte counters for one region
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "nes_loader_defs.svh"

module rom_addr_gen (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  load,
	input  loader_pkg::region_t  load_region,
	input  ines_pkg::byte_count_t load_count,
	input  wire                  step,
	input  ines_pkg::byte_t      byte_data,
	output logic                 bytes_left_zero,
	output logic                 wr_req,
	output ines_pkg::mem_addr_t  wr_addr,
	output ines_pkg::byte_t      wr_data
);

	ines_pkg::mem_addr_t   addr;
	ines_pkg::byte_count_t count;

	always_ff @(posedge clk) begin
		if (reset) begin
			addr  <= `PRG_BASE;
			count <= '0;
		end else if (load) begin
			addr  <= (load_region == loader_pkg::region_chr) ? `CHR_BASE : `PRG_BASE;
			count <= load_count;
		end else if (step) begin
			addr  <= addr + 1'b1;
			count <= count - 1'b1;
		end
	end

	assign bytes_left_zero = (count == '0);

	// Request carries the address before it advances
	assign wr_req  = step;
	assign wr_addr = addr;
	assign wr_data = byte_data;

endmodule

`default_nettype wire

/* loader_fsm.sv */
// ##############################
// Loader FSM
// Sequences header, PRG, CHR, done and fail
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "nes_loader_defs.svh"

module loader_fsm (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   downloading,
	input  wire                   byte_valid,
	input  wire                   hdr_ok,
	input  wire                   bytes_left_zero,
	input  ines_pkg::byte_t       prg_pages,
	input  ines_pkg::byte_t       chr_pages,
	output logic                  hdr_capture,
	output logic [3:0]            hdr_index,
	output loader_pkg::region_t   load_region,
	output ines_pkg::byte_count_t load_count,
	output logic                  load,
	output logic                  step,
	output logic                  flags_latch,
	output logic                  done,
	output logic                  error
);

	loader_pkg::loader_state_t state, state_next;
	logic [3:0] hdr_cnt;
	logic       hdr_full;     // All header bytes stored, verdict pending
	logic       dl_prev;
	logic       dl_rise;
	ines_pkg::byte_count_t prg_bytes, chr_bytes;

	assign dl_rise = downloading && !dl_prev;

	assign prg_bytes = ines_pkg::byte_count_t'(prg_pages) << `PRG_PAGE_SHIFT;
	assign chr_bytes = ines_pkg::byte_count_t'(chr_pages) << `CHR_PAGE_SHIFT;

	assign hdr_capture = byte_valid && (state == loader_pkg::st_header) && !hdr_full;
	assign hdr_index   = hdr_cnt;

	// Only strobes inside a region with room left become writes
	assign step = byte_valid && !bytes_left_zero &&
			((state == loader_pkg::st_prg) || (state == loader_pkg::st_chr));

	always_comb begin
		state_next  = state;
		load        = 1'b0;
		load_region = loader_pkg::region_prg;
		flags_latch = 1'b0;
		case (state)
			loader_pkg::st_header: if (hdr_full) begin
				flags_latch = 1'b1;
				load = hdr_ok;
				state_next = hdr_ok ? loader_pkg::st_prg : loader_pkg::st_fail;
			end
			loader_pkg::st_prg: if (bytes_left_zero) begin
				if (chr_pages != 8'h00) begin
					load = 1'b1;
					load_region = loader_pkg::region_chr;
					state_next = loader_pkg::st_chr;
				end else begin
					state_next = loader_pkg::st_done;   // CHR RAM cart
				end
			end
			loader_pkg::st_chr: if (bytes_left_zero)
				state_next = loader_pkg::st_done;
			default: ;
		endcase
	end

	assign load_count = (load_region == loader_pkg::region_chr) ? chr_bytes : prg_bytes;

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= loader_pkg::st_header;
			hdr_cnt  <= '0;
			hdr_full <= 1'b0;
			dl_prev  <= 1'b0;
		end else begin
			dl_prev <= downloading;
			if (dl_rise) begin
				state    <= loader_pkg::st_header;
				hdr_cnt  <= '0;
				hdr_full <= 1'b0;
			end else begin
				state <= state_next;
				if (hdr_capture) begin
					hdr_cnt  <= hdr_cnt + 1'b1;
					hdr_full <= (hdr_cnt == 4'(`INES_HDR_LEN - 1));
				end else if (hdr_full) begin
					hdr_full <= 1'b0;
				end
			end
		end
	end

	// Status flags set on entry to done or fail, held until restart
	always_ff @(posedge clk) begin
		if (reset || dl_rise) begin
			done  <= 1'b0;
			error <= 1'b0;
		end else if (state_next == loader_pkg::st_fail) begin
			done  <= 1'b1;
			error <= 1'b1;
		end else if (state_next == loader_pkg::st_done) begin
			done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* mem_write_stage.sv */
// ##############################
// Memory write stage
// Holds each write until the console clock-enable slot
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "nes_loader_defs.svh"

module mem_write_stage (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 wr_req,
	input  ines_pkg::mem_addr_t wr_addr,
	input  ines_pkg::byte_t     wr_data,
	output ines_pkg::mem_addr_t mem_addr,
	output ines_pkg::byte_t     mem_data,
	output logic                mem_write
);

	localparam int PHASE_W = $clog2(`CE_PHASES);
	localparam logic [PHASE_W-1:0] RELEASE_PHASE = PHASE_W'(`CE_PHASES - 1);

	logic [PHASE_W-1:0] phase;    // Free running, wraps at CE_PHASES
	logic               pending;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase     <= '0;
			pending   <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			phase     <= phase + 1'b1;
			mem_write <= 1'b0;
			if (wr_req)
				pending <= 1'b1;
			// Fire so the pulse lands in the release slot
			if ((phase == RELEASE_PHASE - 1'b1) && (pending || wr_req)) begin
				mem_write <= 1'b1;
				pending   <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_req) begin
			mem_addr <= wr_addr;
			mem_data <= wr_data;
		end
	end

endmodule

`default_nettype wire

/* nes_loader_top.sv */
// ##############################
// iNES cartridge loader
// Download stream to PRG and CHR memory writes
// ##############################
`timescale 1ns/100ps
`default_nettype none

module nes_loader_top (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     downloading,
	input  wire                     byte_valid,
	input  ines_pkg::byte_t         byte_data,
	input  wire                     invert_mirroring,
	output ines_pkg::mem_addr_t     mem_addr,
	output ines_pkg::byte_t         mem_data,
	output logic                    mem_write,
	output ines_pkg::mapper_flags_t mapper_flags,
	output logic                    done,
	output logic                    error
);

	logic                  hdr_capture;
	logic [3:0]            hdr_index;
	logic                  hdr_ok;
	ines_pkg::byte_t       prg_pages, chr_pages;
	loader_pkg::region_t   load_region;
	ines_pkg::byte_count_t load_count;
	logic                  load, step, flags_latch;
	logic                  bytes_left_zero;
	logic                  wr_req;
	ines_pkg::mem_addr_t   wr_addr;
	ines_pkg::byte_t       wr_data;

	loader_fsm loader_fsm_inst (
		.clk, .reset, .downloading, .byte_valid,
		.hdr_ok, .bytes_left_zero, .prg_pages, .chr_pages,
		.hdr_capture, .hdr_index,
		.load_region, .load_count, .load, .step,
		.flags_latch, .done, .error
	);

	ines_header ines_header_inst (
		.clk, .reset, .hdr_capture, .hdr_index, .byte_data,
		.invert_mirroring, .flags_latch,
		.hdr_ok, .prg_pages, .chr_pages, .mapper_flags
	);

	rom_addr_gen rom_addr_gen_inst (
		.clk, .reset, .load, .load_region, .load_count, .step, .byte_data,
		.bytes_left_zero, .wr_req, .wr_addr, .wr_data
	);

	mem_write_stage mem_write_stage_inst (
		.clk, .reset, .wr_req, .wr_addr, .wr_data,
		.mem_addr, .mem_data, .mem_write
	);

endmodule

`default_nettype wire

/* nes_loader_props.sv */
// ##############################
// Loader assertions
// Write pulse timing and status flags
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "nes_loader_defs.svh"

module nes_loader_props (
	input wire clk,
	input wire reset,
	input wire mem_write,
	input wire done,
	input wire error
);

	localparam int PHASE_W = $clog2(`CE_PHASES);

	logic [PHASE_W-1:0] phase_ref;   // Tracks the console enable phase

	always_ff @(posedge clk) begin
		if (reset)
			phase_ref <= '0;
		else
			phase_ref <= phase_ref + 1'b1;
	end

	write_single_pulse: assert property (@(posedge clk) disable iff (reset)
		mem_write |=> !mem_write)
		else $error("mem_write high on two consecutive cycles");

	write_in_slot: assert property (@(posedge clk) disable iff (reset)
		mem_write |-> (phase_ref == PHASE_W'(`CE_PHASES - 1)))
		else $error("mem_write outside the enable slot");

	error_needs_done: assert property (@(posedge clk) disable iff (reset)
		error |-> done)
		else $error("error without done");

	done_clear_on_reset: assert property (@(posedge clk)
		reset |=> !done)
		else $error("done high after reset");

endmodule

bind nes_loader_top nes_loader_props nes_loader_props_inst (
	.clk, .reset, .mem_write, .done, .error
);

`default_nettype wire

/* tb_nes_loader.sv */
// ##############################
// Testbench for the iNES loader
// Streams images, checks writes and flags
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "nes_loader_defs.svh"

module tb_nes_loader;

	localparam int STROBE_GAP = 5;
	localparam int PRG_PAGE = 1 << 14;
	localparam int CHR_PAGE = 1 << 13;
	// Seven headers, two PRG pages and five CHR pages over all images
	localparam int TOTAL_BYTES = 7 * 16 + 2 * PRG_PAGE + 5 * CHR_PAGE;
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * STROBE_GAP * 3 / 2 + 1000;
	localparam int DONE_WAIT = 50;

	logic clk;
	logic reset;
	logic downloading;
	logic byte_valid;
	ines_pkg::byte_t byte_data;
	logic invert_mirroring;
	ines_pkg::mem_addr_t mem_addr;
	ines_pkg::byte_t mem_data;
	logic mem_write;
	ines_pkg::mapper_flags_t mapper_flags;
	logic done;
	logic error;

	logic [31:0] lfsr;
	ines_pkg::byte_t hdr [16];
	logic [29:0] exp_q [$];      // {address, byte}
	int mismatch_count = 0;
	int other_count = 0;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	nes_loader_top nes_loader_top_inst (
		.clk, .reset, .downloading, .byte_valid, .byte_data, .invert_mirroring,
		.mem_addr, .mem_data, .mem_write, .mapper_flags, .done, .error
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output ines_pkg::byte_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	function automatic ines_pkg::size_code_t ref_size_code(input ines_pkg::byte_t pages);
		ines_pkg::size_code_t code;
		logic found;
		code = 3'd7;
		found = 1'b0;
		for (int k = 0; k < 8; k++) begin
			if (!found && (int'(pages) <= (1 << k))) begin
				code = 3'(k);
				found = 1'b1;
			end
		end
		return code;
	endfunction

	function automatic ines_pkg::mapper_flags_t expected_flags(input ines_pkg::byte_t h [16],
			input logic inv);
		ines_pkg::mapper_flags_t f;
		logic nes2;
		logic dirty;
		logic [3:0] mapper_hi;
		nes2 = (h[7][3:2] == 2'b10);
		dirty = 1'b0;
		for (int i = 8; i < 16; i++) begin
			if (h[i] != 8'h00)
				dirty = !nes2;
		end
		mapper_hi = dirty ? 4'h0 : h[7][7:4];
		f = '0;
		f[7:0] = {mapper_hi, h[6][7:4]};
		f[10:8] = ref_size_code(h[4]);
		f[13:11] = ref_size_code(h[5]);
		f[14] = h[6][0] ^ inv;
		f[15] = (h[5] == 8'h00);    // No CHR ROM means CHR RAM
		f[16] = h[6][3];
		f[24:17] = nes2 ? h[8] : 8'h00;
		return f;
	endfunction

	task automatic check_addr(input ines_pkg::mem_addr_t got, input ines_pkg::mem_addr_t exp,
			input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s address %h, expected %h", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_byte(input ines_pkg::byte_t got, input ines_pkg::byte_t exp,
			input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s data %h, expected %h", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_flags(input ines_pkg::mapper_flags_t got,
			input ines_pkg::mapper_flags_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s flags %h, expected %h", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_status(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	// Every write pulse must match the oldest expected pair
	always @(negedge clk) begin : compare_writes
		logic [29:0] exp;
		if (!reset && mem_write) begin
			if (exp_q.size() == 0) begin
				$display("ERROR at %0t: memory write to %h with no write expected",
					$time, mem_addr);
				other_count++;
			end else begin
				exp = exp_q.pop_front();
				check_addr(mem_addr, exp[29:8], "write");
				check_byte(mem_data, exp[7:0], "write");
			end
		end
	end

	task automatic send_byte(input ines_pkg::byte_t b);
		@(posedge clk);
		#1;
		byte_valid = 1'b1;
		byte_data = b;
		@(posedge clk);
		#1;
		byte_valid = 1'b0;
		repeat (STROBE_GAP - 2) @(posedge clk);
	endtask

	task automatic set_header(input ines_pkg::byte_t prg, input ines_pkg::byte_t chr,
			input ines_pkg::byte_t b6, input ines_pkg::byte_t b7,
			input ines_pkg::byte_t b8, input ines_pkg::byte_t b15);
		hdr[0] = 8'h4E;
		hdr[1] = 8'h45;
		hdr[2] = 8'h53;
		hdr[3] = 8'h1A;
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6] = b6;
		hdr[7] = b7;
		hdr[8] = b8;
		for (int i = 9; i < 15; i++)
			hdr[i] = 8'h00;
		hdr[15] = b15;
	endtask

	task automatic wait_done(output logic seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < DONE_WAIT && !seen; n++) begin
			@(negedge clk);
			seen = done;
		end
	endtask

	task automatic run_image(input logic inv, input logic expect_err, input string name);
		ines_pkg::byte_t b;
		ines_pkg::mem_addr_t addr;
		ines_pkg::mapper_flags_t flags_ref;
		logic seen;
		int n_prg;
		int n_chr;
		flags_ref = expected_flags(hdr, inv);
		n_prg = expect_err ? 0 : int'(hdr[4]) * PRG_PAGE;
		n_chr = expect_err ? 0 : int'(hdr[5]) * CHR_PAGE;
		@(posedge clk);
		#1;
		invert_mirroring = inv;
		downloading = 1'b1;       // Rising edge restarts the loader
		@(posedge clk);
		@(negedge clk);
		check_status(done, 1'b0, {name, " done after restart"});
		check_status(error, 1'b0, {name, " error after restart"});
		for (int i = 0; i < 16; i++)
			send_byte(hdr[i]);
		addr = 22'h000000;
		for (int i = 0; i < n_prg; i++) begin
			random_byte(b);
			exp_q.push_back({addr, b});
			addr = addr + 1'b1;
			send_byte(b);
		end
		addr = 22'h200000;
		for (int i = 0; i < n_chr; i++) begin
			random_byte(b);
			exp_q.push_back({addr, b});
			addr = addr + 1'b1;
			send_byte(b);
		end
		wait_done(seen);
		if (!seen) begin
			$display("ERROR at %0t: %s, done never rose", $time, name);
			other_count++;
		end else begin
			check_status(error, expect_err, {name, " error"});
			if (!expect_err)
				check_flags(mapper_flags, flags_ref, name);
		end
		// Last write may trail done by up to one enable period
		repeat (`CE_PHASES + 1) @(negedge clk);
		if (exp_q.size() != 0) begin
			$display("ERROR at %0t: %s, %0d expected writes never happened",
				$time, name, exp_q.size());
			other_count++;
			exp_q.delete();
		end
		@(posedge clk);
		#1;
		downloading = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	initial begin
		lfsr = 32'h78f8d313;
		reset = 1'b1;
		downloading = 1'b0;
		byte_valid = 1'b0;
		byte_data = 8'h00;
		invert_mirroring = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		set_header(8'd1, 8'd0, 8'h10, 8'h00, 8'h00, 8'h00);
		run_image(1'b0, 1'b0, "basic image");
		set_header(8'd1, 8'd1, 8'h41, 8'h00, 8'h00, 8'h00);
		run_image(1'b0, 1'b0, "PRG and CHR image");
		set_header(8'd0, 8'd3, 8'h39, 8'h58, 8'h21, 8'h00);   // NES 2.0, four-screen
		run_image(1'b1, 1'b0, "NES 2.0 header");
		set_header(8'd0, 8'd0, 8'hA0, 8'hC0, 8'h00, 8'h44);   // Junk in byte 15
		run_image(1'b1, 1'b0, "dirty header");
		set_header(8'd1, 8'd0, 8'h00, 8'h00, 8'h00, 8'h00);
		hdr[2] = 8'h54;
		run_image(1'b0, 1'b1, "bad magic");
		set_header(8'd1, 8'd0, 8'h04, 8'h00, 8'h00, 8'h00);
		run_image(1'b0, 1'b1, "trainer");
		set_header(8'd0, 8'd1, 8'h00, 8'h10, 8'h00, 8'h00);
		run_image(1'b0, 1'b0, "restart image");

		$display("Result: %0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles, the run did not finish",
			WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
ines_pkg.sv
loader_pkg.sv
ines_header.sv
rom_addr_gen.sv
loader_fsm.sv
mem_write_stage.sv
nes_loader_top.sv
nes_loader_props.sv
tb_nes_loader.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_nes_loader
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and log"

$(BUILD_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
